//--- rtl/script_pkg.sv
/* shared types for the script engine: opcodes, instruction word, feedback and packets
   RTL and testbench refer to everything here by scoped name */
package script_pkg;

    // byte distance between two script words
    localparam logic [7:0] PC_STEP = 8'd2;
    // default start credit of each output queue
    localparam int DEFAULT_CREDITS = 4;

    // code 7 is not assigned and runs as nop
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_TARGET  = 3'd1,
        OP_OPERATE = 3'd2,
        OP_JUMP    = 3'd3,
        OP_WAIT    = 3'd4,
        OP_GAME    = 3'd5,
        OP_HALT    = 3'd6
    } opcode_e;

    // operate meaning of the function field
    typedef enum logic [1:0] {
        FN_GET      = 2'd0,
        FN_PUT      = 2'd1,
        FN_INTERACT = 2'd2,
        FN_THROW    = 2'd3
    } func_e;

    // jump and wait meanings share the same two codes
    localparam func_e FN_ALWAYS = FN_GET;
    localparam func_e FN_COND   = FN_PUT;
    localparam func_e FN_TICKS  = FN_GET;
    localparam func_e FN_UNTIL  = FN_PUT;

    // game opcode copies the function field straight into this
    typedef enum logic [1:0] {
        GS_IDLE  = 2'd0,
        GS_RUN   = 2'd1,
        GS_PAUSE = 2'd2,
        GS_END   = 2'd3
    } game_state_e;

    // script word, num in the high byte and opcode in the low bits
    typedef struct packed {
        logic [7:0] num;
        logic [2:0] cond;
        func_e      func;
        opcode_e    op;
    } instr_t;

    // traveler status, bit 0 is in_front
    typedef struct packed {
        logic machine_has_item;
        logic machine_processing;
        logic hand_full;
        logic in_front;
    } feedback_t;

    typedef struct packed {
        logic [4:0] machine;
        logic [2:0] seq;
    } target_pkt_t;

    typedef struct packed {
        func_e      op;
        logic [5:0] seq;
    } operate_pkt_t;

    // cond[1:0] picks the feedback bit, cond[2] inverts it
    function automatic logic cond_holds(input logic [2:0] cond, input feedback_t fb);
        logic [3:0] bits;
        bits = fb;
        return bits[cond[1:0]] ^ cond[2];
    endfunction

endpackage

//--- rtl/credit_queue.sv
/* small FIFO whose output is gated by a sender side credit counter
   each valid beat spends one credit, i_credit gives one back per cycle high */
`timescale 1ns/10ps

module credit_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4,
    parameter int  CREDITS   = 4
) (
    input  logic     clk,
    input  logic     res,
    input  logic     i_push,
    input  payload_t i_data,
    output logic     o_full,
    input  logic     i_credit,
    output logic     o_valid,
    output payload_t o_data
);
    // pointer width kept at least one bit for depth 1
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int NW = $clog2(DEPTH + 1);
    localparam int CW = $clog2(CREDITS + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [NW-1:0]   count;
    logic [CW-1:0]   credit_cnt;

    assign o_full  = (count == NW'(DEPTH));
    // consumer takes every valid beat, so valid is also the pop
    assign o_valid = (count != '0) && (credit_cnt != '0);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk or posedge res) begin
        if (res) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CW'(CREDITS);
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (o_valid) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, o_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // returned credits never exceed the ones spent
            case ({i_credit, o_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

//--- rtl/action_issuer.sv
/* executes target, operate and game instructions for the sequencer
   packets go to the credit queues, stalling while the chosen queue is full */
`timescale 1ns/10ps

module action_issuer (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     i_start,
    input  script_pkg::instr_t       i_instr,
    input  logic                     i_tgt_full,
    input  logic                     i_op_full,
    output logic                     o_tgt_push,
    output script_pkg::target_pkt_t  o_tgt_pkt,
    output logic                     o_op_push,
    output script_pkg::operate_pkt_t o_op_pkt,
    output script_pkg::game_state_e  o_game_state,
    output logic                     o_done
);
    typedef enum logic [1:0] {
        A_IDLE,
        A_TGT,
        A_OP,
        A_GAME
    } act_state_e;

    act_state_e state;
    logic [2:0] tgt_seq;
    logic [5:0] op_seq;

    // packet contents follow the held instruction word
    always_comb begin
        o_tgt_pkt.machine = i_instr.num[4:0];
        o_tgt_pkt.seq     = tgt_seq;
        o_op_pkt.op       = i_instr.func;
        o_op_pkt.seq      = op_seq;
    end

    // push as soon as the queue has room
    assign o_tgt_push = (state == A_TGT) && !i_tgt_full;
    assign o_op_push  = (state == A_OP) && !i_op_full;
    assign o_done     = o_tgt_push || o_op_push || (state == A_GAME);

    always_ff @(posedge clk or posedge res) begin
        if (res) begin
            state        <= A_IDLE;
            tgt_seq      <= 3'd0;
            op_seq       <= 6'd0;
            o_game_state <= script_pkg::GS_IDLE;
        end else begin
            if (o_tgt_push) begin
                tgt_seq <= tgt_seq + 3'd1;
            end
            if (o_op_push) begin
                op_seq <= op_seq + 6'd1;
            end
            if (i_start) begin
                case (i_instr.op)
                    script_pkg::OP_TARGET:  state <= A_TGT;
                    script_pkg::OP_OPERATE: state <= A_OP;
                    default: begin
                        // game word, func is the new state
                        state        <= A_GAME;
                        o_game_state <= script_pkg::game_state_e'(i_instr.func);
                    end
                endcase
            end else if (o_done) begin
                state <= A_IDLE;
            end
        end
    end

endmodule

//--- rtl/flow_unit.sv
/* jump and wait execution, tests the traveler feedback and counts ms ticks
   returns done plus taken, taken only means something for jumps */
`timescale 1ns/10ps

module flow_unit (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  i_start,
    input  script_pkg::instr_t    i_instr,
    input  script_pkg::feedback_t i_feedback,
    input  logic                  i_ms_tick,
    output logic                  o_done,
    output logic                  o_taken
);
    typedef enum logic [1:0] {
        F_IDLE,
        F_JUMP,
        F_TICKS,
        F_UNTIL
    } flow_state_e;

    flow_state_e state;
    logic [7:0]  tick_cnt;
    logic        tick_q;
    logic        tick_rise;
    logic        cond_ok;
    logic        ticks_done;

    assign cond_ok   = script_pkg::cond_holds(i_instr.cond, i_feedback);
    assign tick_rise = i_ms_tick && !tick_q;

    // zero count ends right away, otherwise on the last rising tick
    assign ticks_done = (tick_cnt == 8'd0) || (tick_rise && tick_cnt == 8'd1);

    always_comb begin
        o_done  = 1'b0;
        o_taken = 1'b0;
        case (state)
            F_JUMP: begin
                o_done  = 1'b1;
                o_taken = (i_instr.func == script_pkg::FN_ALWAYS) || cond_ok;
            end
            F_TICKS: o_done = ticks_done;
            F_UNTIL: o_done = cond_ok;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge res) begin
        if (res) begin
            state    <= F_IDLE;
            tick_cnt <= 8'd0;
            tick_q   <= 1'b0;
        end else begin
            tick_q <= i_ms_tick;
            if (i_start) begin
                tick_cnt <= i_instr.num;
                if (i_instr.op == script_pkg::OP_JUMP) begin
                    state <= F_JUMP;
                end else if (i_instr.func == script_pkg::FN_UNTIL) begin
                    state <= F_UNTIL;
                end else begin
                    state <= F_TICKS;
                end
            end else begin
                if (state == F_TICKS && tick_rise && tick_cnt != 8'd0) begin
                    tick_cnt <= tick_cnt - 8'd1;
                end
                if (o_done) begin
                    state <= F_IDLE;
                end
            end
        end
    end

endmodule

//--- rtl/script_sequencer.sv
/* program counter and instruction dispatch, one script word in flight at a time
   starts the unit picked by the opcode and moves the pc when that unit is done */
`timescale 1ns/10ps

module script_sequencer (
    input  logic               clk,
    input  logic               res,
    input  script_pkg::instr_t i_script,
    input  logic               i_step_mode,
    input  logic               i_step,
    input  logic               i_act_done,
    input  logic               i_flow_done,
    input  logic               i_flow_taken,
    output logic [7:0]         o_pc,
    output script_pkg::instr_t o_instr,
    output logic               o_act_start,
    output logic               o_flow_start,
    output logic               o_halted
);
    // fetch waits one cycle for memory, issue pulses start, wait collects done
    typedef enum logic [1:0] {
        S_FETCH,
        S_ISSUE,
        S_WAIT,
        S_HALT
    } state_e;

    state_e             state;
    script_pkg::instr_t instr_q;
    logic               step_pend;
    logic               fetch_go;
    logic               to_act;
    logic               to_flow;
    logic               is_halt;
    logic               own_done;
    logic               retire;
    logic [7:0]         next_pc;

    // opcode decode of the latched word
    always_comb begin
        to_act  = 1'b0;
        to_flow = 1'b0;
        is_halt = 1'b0;
        case (instr_q.op)
            script_pkg::OP_TARGET,
            script_pkg::OP_OPERATE,
            script_pkg::OP_GAME: to_act = 1'b1;
            script_pkg::OP_JUMP,
            script_pkg::OP_WAIT: to_flow = 1'b1;
            script_pkg::OP_HALT: is_halt = 1'b1;
            // nop and the spare code fall through
            default: ;
        endcase
    end

    assign o_act_start  = (state == S_ISSUE) && to_act;
    assign o_flow_start = (state == S_ISSUE) && to_flow;
    assign o_instr      = instr_q;
    assign o_halted     = (state == S_HALT);

    // nop retires itself one cycle after issue
    assign own_done = !to_act && !to_flow;
    assign retire   = (state == S_WAIT) && (i_act_done || i_flow_done || own_done);

    // only a taken jump loads num, everything else steps forward
    assign next_pc = (i_flow_done && i_flow_taken) ? instr_q.num
                                                   : o_pc + script_pkg::PC_STEP;

    // in step mode a fetch needs a pulse, either now or remembered
    assign fetch_go = (state == S_FETCH) && (!i_step_mode || step_pend || i_step);

    always_ff @(posedge clk or posedge res) begin
        if (res) begin
            state     <= S_FETCH;
            o_pc      <= 8'd0;
            step_pend <= 1'b0;
        end else begin
            // pulses that land mid instruction are kept for the next fetch
            if (!i_step_mode || fetch_go) begin
                step_pend <= 1'b0;
            end else if (i_step) begin
                step_pend <= 1'b1;
            end
            case (state)
                S_FETCH: begin
                    if (fetch_go) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    state <= is_halt ? S_HALT : S_WAIT;
                end
                S_WAIT: begin
                    if (retire) begin
                        o_pc  <= next_pc;
                        state <= S_FETCH;
                    end
                end
                // halt holds pc until reset
                default: state <= S_HALT;
            endcase
        end
    end

    // word is valid by the end of the fetch cycle
    always_ff @(posedge clk) begin
        if (fetch_go) begin
            instr_q <= i_script;
        end
    end

endmodule

//--- rtl/script_engine_top.sv
/* script engine top, wires the sequencer, both execution units and the two packet queues
   script memory sits outside and is addressed through o_pc */
`timescale 1ns/10ps

module script_engine_top #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = script_pkg::DEFAULT_CREDITS
) (
    input  logic                     clk,
    input  logic                     res,
    input  script_pkg::instr_t       i_script,
    input  script_pkg::feedback_t    i_feedback,
    input  logic                     i_ms_tick,
    input  logic                     i_step_mode,
    input  logic                     i_step,
    input  logic                     i_tgt_credit,
    input  logic                     i_op_credit,
    output logic [7:0]               o_pc,
    output logic                     o_tgt_valid,
    output script_pkg::target_pkt_t  o_tgt_pkt,
    output logic                     o_op_valid,
    output script_pkg::operate_pkt_t o_op_pkt,
    output script_pkg::game_state_e  o_game_state,
    output logic                     o_halted
);
    // sequencer to units
    script_pkg::instr_t instr;
    logic act_start;
    logic act_done;
    logic flow_start;
    logic flow_done;
    logic flow_taken;

    // issuer to queues
    logic tgt_push;
    logic tgt_full;
    logic op_push;
    logic op_full;
    script_pkg::target_pkt_t  tgt_pkt;
    script_pkg::operate_pkt_t op_pkt;

    script_sequencer u_seq (
        .clk          (clk),
        .res          (res),
        .i_script     (i_script),
        .i_step_mode  (i_step_mode),
        .i_step       (i_step),
        .i_act_done   (act_done),
        .i_flow_done  (flow_done),
        .i_flow_taken (flow_taken),
        .o_pc         (o_pc),
        .o_instr      (instr),
        .o_act_start  (act_start),
        .o_flow_start (flow_start),
        .o_halted     (o_halted)
    );

    action_issuer u_act (
        .clk          (clk),
        .res          (res),
        .i_start      (act_start),
        .i_instr      (instr),
        .i_tgt_full   (tgt_full),
        .i_op_full    (op_full),
        .o_tgt_push   (tgt_push),
        .o_tgt_pkt    (tgt_pkt),
        .o_op_push    (op_push),
        .o_op_pkt     (op_pkt),
        .o_game_state (o_game_state),
        .o_done       (act_done)
    );

    flow_unit u_flow (
        .clk        (clk),
        .res        (res),
        .i_start    (flow_start),
        .i_instr    (instr),
        .i_feedback (i_feedback),
        .i_ms_tick  (i_ms_tick),
        .o_done     (flow_done),
        .o_taken    (flow_taken)
    );

    // target machine stream
    credit_queue #(
        .payload_t (script_pkg::target_pkt_t),
        .DEPTH     (DEPTH),
        .CREDITS   (CREDITS)
    ) u_tgt_q (
        .clk      (clk),
        .res      (res),
        .i_push   (tgt_push),
        .i_data   (tgt_pkt),
        .o_full   (tgt_full),
        .i_credit (i_tgt_credit),
        .o_valid  (o_tgt_valid),
        .o_data   (o_tgt_pkt)
    );

    // operate machine stream
    credit_queue #(
        .payload_t (script_pkg::operate_pkt_t),
        .DEPTH     (DEPTH),
        .CREDITS   (CREDITS)
    ) u_op_q (
        .clk      (clk),
        .res      (res),
        .i_push   (op_push),
        .i_data   (op_pkt),
        .o_full   (op_full),
        .i_credit (i_op_credit),
        .o_valid  (o_op_valid),
        .o_data   (o_op_pkt)
    );

endmodule

//--- test/tb_clock.sv
/* free running testbench clock, period given in ns */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- test/script_engine_props.sv
/* concurrent checks on the script engine top, attached with bind
   covers credit use, packet loss, step mode pacing and halt */
`timescale 1ns/10ps

module script_engine_props #(
    parameter int CREDITS = 4,
    parameter int DEPTH   = 4
) (
    input logic       clk,
    input logic       res,
    input logic       i_step_mode,
    input logic       i_step,
    input logic       i_tgt_credit,
    input logic       i_op_credit,
    input logic [7:0] i_pc,
    input logic       i_tgt_valid,
    input logic       i_op_valid,
    input logic       i_halted,
    input logic       i_tgt_push,
    input logic       i_op_push
);
    // beats sent minus credits returned
    int tgt_out;
    int op_out;
    // packets pushed but not yet sent
    int tgt_held;
    int op_held;
    // read by the testbench for its closing count
    int fail_cnt = 0;
    logic [7:0] pc_q;
    logic       step_seen;

    always_ff @(posedge clk or posedge res) begin
        if (res) begin
            tgt_out   <= 0;
            op_out    <= 0;
            tgt_held  <= 0;
            op_held   <= 0;
            pc_q      <= 8'd0;
            step_seen <= 1'b0;
        end else begin
            tgt_out  <= tgt_out + int'(i_tgt_valid) - int'(i_tgt_credit);
            op_out   <= op_out + int'(i_op_valid) - int'(i_op_credit);
            tgt_held <= tgt_held + int'(i_tgt_push) - int'(i_tgt_valid);
            op_held  <= op_held + int'(i_op_push) - int'(i_op_valid);
            pc_q     <= i_pc;
            // a pc move uses up the pulses seen so far
            step_seen <= (i_pc != pc_q) ? i_step : (step_seen | i_step);
        end
    end

    a_tgt_credit: assert property (@(posedge clk) disable iff (res) tgt_out <= CREDITS)
        else begin fail_cnt++; $error("target stream sent beyond its credits"); end
    a_op_credit: assert property (@(posedge clk) disable iff (res) op_out <= CREDITS)
        else begin fail_cnt++; $error("operate stream sent beyond its credits"); end

    // held count stays inside the FIFO, so nothing vanishes or appears
    a_tgt_held: assert property (@(posedge clk) disable iff (res)
        tgt_held >= 0 && tgt_held <= DEPTH)
        else begin fail_cnt++; $error("target packets lost or duplicated"); end
    a_op_held: assert property (@(posedge clk) disable iff (res)
        op_held >= 0 && op_held <= DEPTH)
        else begin fail_cnt++; $error("operate packets lost or duplicated"); end

    a_step: assert property (@(posedge clk) disable iff (res)
        (i_step_mode && i_pc != pc_q) |-> step_seen)
        else begin fail_cnt++; $error("pc moved without a step pulse"); end

    a_halt: assert property (@(posedge clk) disable iff (res)
        i_halted |=> (i_halted && $stable(i_pc)))
        else begin fail_cnt++; $error("halt released or pc moved while halted"); end

endmodule

//--- test/tb_top.sv
/* testbench for the script engine, models script memory, feedback, ticks and credit return
   runs a full script and then a short one in step mode, checks packets and game states */
`timescale 1ns/10ps

module tb_top;
    localparam int RESET_CYCLES = 8;
    localparam int TICK_GAP     = 7;
    localparam int MAX_CDELAY   = 6;
    // long enough that the next beat of a stream finds no credit left
    localparam int SLOW_CDELAY  = 16;
    // one credit per stream so credit return paces every later beat
    localparam int DUT_CREDITS  = 1;
    localparam int STEP_GAP     = 6;
    localparam int MAIN_WORDS   = 16;
    localparam int STEP_WORDS   = 3;
    // per word budget covers a tick wait of 5, credit delay and step spacing
    localparam int WORD_CYCLES  = 5 * TICK_GAP + 2 * (SLOW_CDELAY + MAX_CDELAY) + STEP_GAP + 20;
    localparam int LIMIT_CYCLES = (MAIN_WORDS + STEP_WORDS) * WORD_CYCLES + 4 * RESET_CYCLES;
    localparam logic [7:0] TICK_PC  = 8'd18;
    localparam logic [7:0] UNTIL_PC = 8'd22;
    localparam logic [4:0] AFTER_TICK_MACHINE = 5'd7;

    logic clk;
    logic res;
    logic [15:0] script [128];
    script_pkg::feedback_t i_feedback;
    logic i_ms_tick;
    logic i_step_mode;
    logic i_step;
    logic i_tgt_credit;
    logic i_op_credit;
    logic [7:0] o_pc;
    logic o_tgt_valid;
    logic o_op_valid;
    logic o_halted;
    script_pkg::target_pkt_t  o_tgt_pkt;
    script_pkg::operate_pkt_t o_op_pkt;
    script_pkg::game_state_e  o_game_state;

    script_pkg::target_pkt_t  exp_tgt [$];
    script_pkg::operate_pkt_t exp_op [$];
    script_pkg::game_state_e  exp_gs [$];
    script_pkg::game_state_e  last_gs;
    int errors = 0;
    int tick_total = 0;
    int tick_base = 0;
    int tgt_owed = 0;
    int tgt_wait = 0;
    int op_owed = 0;
    int op_wait = 0;
    int tick_div = 0;
    logic [7:0] pc_prev;

    tb_clock #(.PERIOD_NS(100)) u_clk (.o_clk(clk));

    script_engine_top #(.CREDITS(DUT_CREDITS)) u_dut (
        .clk(clk), .res(res), .i_script(script[o_pc[7:1]]), .i_feedback(i_feedback),
        .i_ms_tick(i_ms_tick), .i_step_mode(i_step_mode), .i_step(i_step),
        .i_tgt_credit(i_tgt_credit), .i_op_credit(i_op_credit), .o_pc(o_pc),
        .o_tgt_valid(o_tgt_valid), .o_tgt_pkt(o_tgt_pkt), .o_op_valid(o_op_valid),
        .o_op_pkt(o_op_pkt), .o_game_state(o_game_state), .o_halted(o_halted)
    );

    bind script_engine_top script_engine_props #(.CREDITS(CREDITS), .DEPTH(DEPTH)) u_props (
        .clk(clk), .res(res), .i_step_mode(i_step_mode), .i_step(i_step),
        .i_tgt_credit(i_tgt_credit), .i_op_credit(i_op_credit), .i_pc(o_pc),
        .i_tgt_valid(o_tgt_valid), .i_op_valid(o_op_valid), .i_halted(o_halted),
        .i_tgt_push(tgt_push), .i_op_push(op_push)
    );

    // word layout num, cond, func, op from high to low
    function automatic logic [15:0] make_word(input logic [2:0] op, input logic [1:0] func,
                                              input logic [2:0] cond, input logic [7:0] num);
        return {num, cond, func, op};
    endfunction

    // unused words hold the spare opcode with num set from the address
    task automatic clear_script();
        for (int i = 0; i < 128; i++) begin
            script[i] = {8'(i), 5'd0, 3'd7};
        end
    endtask

    // walk the script with in_front high and every until condition met
    task automatic build_expected();
        logic [15:0] w;
        logic [3:0]  fb_model;
        logic [7:0]  pc;
        logic        bit_ok;
        int          tseq;
        int          oseq;
        fb_model = 4'b0001;
        pc = 8'd0;
        tseq = 0;
        oseq = 0;
        for (int n = 0; n < 64; n++) begin
            w = script[pc[7:1]];
            bit_ok = fb_model[w[6:5]] ^ w[7];
            if (w[2:0] == 3'd6) begin
                break;
            end
            pc = pc + 8'd2;
            case (w[2:0])
                3'd1: begin
                    exp_tgt.push_back({w[12:8], 3'(tseq)});
                    tseq++;
                end
                3'd2: begin
                    exp_op.push_back({w[4:3], 6'(oseq)});
                    oseq++;
                end
                3'd3: if (w[4:3] == 2'd0 || bit_ok) pc = w[15:8];
                3'd5: exp_gs.push_back(script_pkg::game_state_e'(w[4:3]));
                default: ;
            endcase
        end
    endtask

    task automatic drain();
        while (exp_tgt.size() != 0 || exp_op.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // ms tick pulse every TICK_GAP cycles
    always @(posedge clk) begin
        tick_div <= (tick_div == TICK_GAP - 1) ? 0 : tick_div + 1;
        i_ms_tick <= (tick_div == 0);
        if (i_ms_tick && tick_div == 1) begin
            tick_total <= tick_total + 1;
        end
        pc_prev <= o_pc;
        if (o_pc == TICK_PC && pc_prev != TICK_PC) begin
            tick_base <= tick_total;
        end
    end

    // one credit back per sent beat, the delay only runs while a credit is owed
    always @(posedge clk) begin
        if (res) begin
            tgt_owed = 0;
            tgt_wait = SLOW_CDELAY;
            op_owed = 0;
            op_wait = SLOW_CDELAY;
            i_tgt_credit <= 1'b0;
            i_op_credit <= 1'b0;
        end else begin
            tgt_owed += int'(o_tgt_valid);
            op_owed += int'(o_op_valid);
            i_tgt_credit <= (tgt_owed > 0 && tgt_wait == 0);
            if (tgt_owed > 0 && tgt_wait == 0) begin
                tgt_owed--;
                tgt_wait = SLOW_CDELAY + $urandom % MAX_CDELAY;
            end else if (tgt_owed > 0) begin
                tgt_wait--;
            end
            i_op_credit <= (op_owed > 0 && op_wait == 0);
            if (op_owed > 0 && op_wait == 0) begin
                op_owed--;
                op_wait = SLOW_CDELAY + $urandom % MAX_CDELAY;
            end else if (op_owed > 0) begin
                op_wait--;
            end
        end
    end

    // output monitors
    always @(posedge clk) begin
        script_pkg::target_pkt_t  want_t;
        script_pkg::operate_pkt_t want_o;
        if (res) begin
            last_gs = script_pkg::GS_IDLE;
        end else begin
            if (o_tgt_valid) begin
                if (exp_tgt.size() == 0) begin
                    errors++;
                    $display("%0t target packet %h arrived with none expected", $time, o_tgt_pkt);
                end else begin
                    want_t = exp_tgt.pop_front();
                    assert (o_tgt_pkt == want_t) else begin
                        errors++;
                        $display("[FAIL] %0t o_tgt_pkt expected %h got %h",
                                 $time, want_t, o_tgt_pkt);
                    end
                    if (want_t.machine == AFTER_TICK_MACHINE) begin
                        assert (tick_total - tick_base >= 5) else begin
                            errors++;
                            $display("[FAIL] %0t tick count expected %0d got %0d",
                                     $time, 5, tick_total - tick_base);
                        end
                    end
                end
            end
            if (o_op_valid) begin
                if (exp_op.size() == 0) begin
                    errors++;
                    $display("%0t operate packet %h arrived with none expected", $time, o_op_pkt);
                end else begin
                    want_o = exp_op.pop_front();
                    assert (o_op_pkt == want_o) else begin
                        errors++;
                        $display("[FAIL] %0t o_op_pkt expected %h got %h",
                                 $time, want_o, o_op_pkt);
                    end
                    // interact comes right after the until wait on hand_full
                    if (want_o.op == script_pkg::FN_INTERACT) begin
                        assert (i_feedback.hand_full) else begin
                            errors++;
                            $display("[FAIL] %0t i_feedback.hand_full expected 1 got 0", $time);
                        end
                    end
                end
            end
            if (o_game_state != last_gs) begin
                last_gs = o_game_state;
                assert (exp_gs.size() != 0 && o_game_state == exp_gs[0]) else begin
                    errors++;
                    $display("[FAIL] %0t o_game_state expected %0d got %0d", $time,
                             exp_gs.size() ? exp_gs[0] : 2'd0, o_game_state);
                end
                if (exp_gs.size() != 0) begin
                    void'(exp_gs.pop_front());
                end
            end
        end
    end

    // hand_full rises a while after the until wait begins
    initial begin
        wait (o_pc == UNTIL_PC && res == 1'b0);
        repeat (12) @(posedge clk);
        i_feedback.hand_full <= 1'b1;
    end

    initial begin
        #(LIMIT_CYCLES * 100);
        $display("watchdog expired before the scripts finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h5e81));
        res = 1'b1;
        i_feedback = 4'b0001;
        i_ms_tick = 1'b0;
        i_step_mode = 1'b0;
        i_step = 1'b0;
        i_tgt_credit = 1'b0;
        i_op_credit = 1'b0;
        clear_script();
        script[0]  = make_word(3'd5, 2'd1, 3'd0, 8'd0);
        script[1]  = make_word(3'd1, 2'd0, 3'd0, 8'd3);
        script[2]  = make_word(3'd2, 2'd0, 3'd0, 8'd0);
        // taken on in_front and skips two commands
        script[3]  = make_word(3'd3, 2'd1, 3'b000, 8'd12);
        script[4]  = make_word(3'd1, 2'd0, 3'd0, 8'd9);
        script[5]  = make_word(3'd2, 2'd3, 3'd0, 8'd0);
        // inverted in_front falls through
        script[6]  = make_word(3'd3, 2'd1, 3'b100, 8'd18);
        script[7]  = make_word(3'd1, 2'd0, 3'd0, 8'd5);
        script[8]  = make_word(3'd2, 2'd1, 3'd0, 8'd0);
        script[9]  = make_word(3'd4, 2'd0, 3'd0, 8'd5);
        script[10] = make_word(3'd1, 2'd0, 3'd0, 8'd7);
        // wait until hand_full
        script[11] = make_word(3'd4, 2'd1, 3'b001, 8'd0);
        script[12] = make_word(3'd2, 2'd2, 3'd0, 8'd0);
        script[13] = make_word(3'd5, 2'd2, 3'd0, 8'd0);
        script[14] = make_word(3'd5, 2'd3, 3'd0, 8'd0);
        script[15] = make_word(3'd6, 2'd0, 3'd0, 8'd0);
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b0;
        while (!o_halted) @(posedge clk);
        drain();
        repeat (RESET_CYCLES) @(posedge clk);

        // second run in step mode
        res <= 1'b1;
        i_step_mode <= 1'b1;
        clear_script();
        script[0] = make_word(3'd1, 2'd0, 3'd0, 8'd11);
        script[1] = make_word(3'd2, 2'd1, 3'd0, 8'd0);
        script[2] = make_word(3'd6, 2'd0, 3'd0, 8'd0);
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b0;
        while (!o_halted) begin
            @(posedge clk);
            i_step <= 1'b1;
            @(posedge clk);
            i_step <= 1'b0;
            repeat (STEP_GAP) @(posedge clk);
        end
        drain();
        repeat (RESET_CYCLES) @(posedge clk);
        assert (exp_gs.size() == 0) else begin
            errors++;
            $display("not all scripted game states were reached");
        end
        errors += u_dut.u_props.fail_cnt;
        $display("checks done, errors %0d, of them assertion failures %0d",
                 errors, u_dut.u_props.fail_cnt);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/script_pkg.sv
rtl/credit_queue.sv
rtl/action_issuer.sv
rtl/flow_unit.sv
rtl/script_sequencer.sv
rtl/script_engine_top.sv
test/tb_clock.sv
test/script_engine_props.sv
test/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_top
FLIST     := verilog.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation completed successfully
SRCS      := $(filter-out +incdir%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
